/* list.f */
hw/wiscPkg.sv
hw/regFile.sv
hw/alu.sv
hw/branchUnit.sv
hw/wordMemory.sv
hw/instrDecode.sv
hw/cpuCore.sv
hw/wiscSystem.sv
bench/cpu_assert.sv
bench/wiscTb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = wiscTb
LIST  = list.f
LOG   = sim.log
PASS  = sim passed

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

/* bench/wiscTb.sv */
module wiscTb;

	timeunit 1ns;
	timeprecision 100ps;

	import wiscPkg::*;

	localparam int          cycleLimit = 200;               // Every program halts well before this
	localparam logic [15:0] hltWord    = {opHlt, 12'h000};

	logic        clk      = 1'b0;
	logic        arstN    = 1'b0;
	logic        loadEn   = 1'b0;
	logic [7:0]  loadAddr = '0;
	logic [15:0] loadData = '0;
	logic [15:0] pc;
	logic        hlt;

	logic [15:0] prog [$];                                   // Program being assembled
	int          skipped;                                    // Fail HLTs jumped over on the pass path
	integer      seed       = 32'hdba6_bc3a;
	int          errors     = 0;
	int          checkCount = 0;

	always #50 clk = ~clk;

	wiscSystem uut (.clk, .arstN, .loadEn, .loadAddr, .loadData, .pc, .hlt);

	//////////////////////////////////////////////////////////////
	// Assembler
	//////////////////////////////////////////////////////////////

	function automatic logic [15:0] regOp(opcodeT op, logic [3:0] rd, logic [3:0] rs,
		logic [3:0] rt);
		return {op, rd, rs, rt};                             // rt doubles as 4-bit immediate
	endfunction

	function automatic logic [15:0] byteOp(opcodeT op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] branchOp(condT c, logic [8:0] offset);
		return {opB, c, offset};                             // Offset in words from PC plus 2
	endfunction

	function automatic logic [15:0] jumpReg(condT c, logic [3:0] rs);
		return {opBr, c, 1'b0, rs, 4'h0};
	endfunction

	//////////////////////////////////////////////////////////////
	// Reference models
	//////////////////////////////////////////////////////////////

	function automatic int trueSum(logic [15:0] a, logic [15:0] b, logic sub);
		return sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
	endfunction

	function automatic logic [15:0] satSum(logic [15:0] a, logic [15:0] b, logic sub);
		int s;
		s = trueSum(a, b, sub);
		if (s > 32767)
			return 16'h7fff;
		if (s < -32768)
			return 16'h8000;                                 // Clamp low
		return 16'(s);
	endfunction

	function automatic logic [15:0] nibbleSat(logic [15:0] a, logic [15:0] b);
		logic [15:0] r;
		int          s;
		r = '0;
		for (int i = 0; i < 4; i++)
		begin
			s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
			r[4*i +: 4] = (s > 7) ? 4'h7 : (s < -8) ? 4'h8 : 4'(s);
		end
		return r;
	endfunction

	function automatic logic [15:0] modelResult(opcodeT op, logic [15:0] a, logic [15:0] b);
		case (op)
			opAdd:   return satSum(a, b, 1'b0);
			opSub:   return satSum(a, b, 1'b1);
			opXor:   return a ^ b;
			opRed:   return 16'(int'($signed(a[15:8])) + int'($signed(a[7:0]))
				+ int'($signed(b[15:8])) + int'($signed(b[7:0])));
			opSll:   return a << b[3:0];
			opSra:   return 16'($signed(a) >>> b[3:0]);
			opRor:   return (a >> b[3:0]) | (a << (16 - int'(b[3:0])));   // Low bits wrap to top
			default: return nibbleSat(a, b);                // PADDSB
		endcase
	endfunction

	function automatic logic condHolds(condT c, logic z, logic v, logic n);
		case (c)
			condNe:  return !z;
			condEq:  return z;
			condGt:  return !z && !n;
			condLt:  return n;
			condGe:  return z || (!z && !n);
			condLe:  return n || z;
			condOv:  return v;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [15:0] randWord();
		return 16'($random(seed));
	endfunction

	function automatic logic [15:0] randWithTop(logic [3:0] top);
		logic [15:0] w;
		w = randWord();
		return {top, w[11:0]};                               // Steers the sign and magnitude
	endfunction

	function automatic logic [15:0] lastAddr(int back);
		return 16'(2 * (prog.size() - 1 - back));
	endfunction

	//////////////////////////////////////////////////////////////
	// Program building and running
	//////////////////////////////////////////////////////////////

	task automatic emit(logic [15:0] word);
		prog.push_back(word);
	endtask

	task automatic newProgram();
		prog.delete();
		skipped = 0;
	endtask

	task automatic loadConst(logic [3:0] rd, logic [15:0] value);
		emit(byteOp(opLlb, rd, value[7:0]));
		emit(byteOp(opLhb, rd, value[15:8]));
	endtask

	// Branch over a fail HLT
	task automatic branchOrFail(condT c);
		emit(branchOp(c, 9'd1));
		emit(hltWord);
		skipped++;
	endtask

	task automatic checkEq(logic [3:0] ra, logic [3:0] rb);
		emit(regOp(opSub, 4'd15, ra, rb));                   // Z set only when equal
		branchOrFail(condEq);
	endtask

	task automatic finishRun();
		errors += int'(uut.core.props.failCount);            // Bound assertion failures
		$display("Checks: %0d, errors: %0d", checkCount, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	task automatic runProgram(string name, logic [15:0] expPc, int expCycles);
		int cycles;
		arstN = 1'b0;
		for (int i = 0; i < prog.size(); i++)
		begin
			@(posedge clk);
			#10;
			loadEn   = 1'b1;
			loadAddr = 8'(i);
			loadData = prog[i];
		end
		@(posedge clk);
		#10;
		loadEn = 1'b0;
		repeat (3)
		begin
			@(posedge clk);
			#10;
		end
		checkCount++;
		if (pc !== 16'h0000 || hlt !== 1'b0)
		begin
			errors++;
			$display("Fail %s: in reset expected pc 0000 hlt 0, actual pc %h hlt %b", name, pc, hlt);
		end
		arstN  = 1'b1;
		cycles = 0;
		while (hlt !== 1'b1 && cycles < cycleLimit)
		begin
			@(posedge clk);
			#10;
			cycles++;
		end
		if (hlt !== 1'b1)
		begin
			errors++;
			$display("Timeout in %s: hlt stayed low for %0d cycles", name, cycleLimit);
			finishRun();
		end
		else
		begin
			checkCount += 2;
			if (pc !== expPc)
			begin
				errors++;
				$display("Fail %s: expected pc %h, actual pc %h", name, expPc, pc);
			end
			if (cycles != expCycles)
			begin
				errors++;
				$display("Fail %s: expected %0d cycles, actual %0d", name, expCycles, cycles);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////

	task automatic computeTest(opcodeT op, logic [15:0] a, logic [15:0] b, string what);
		newProgram();
		loadConst(4'd1, a);
		loadConst(4'd2, b);
		emit(regOp(op, 4'd3, 4'd1, (op inside {opSll, opSra, opRor}) ? b[3:0] : 4'd2));
		loadConst(4'd4, modelResult(op, a, b));              // Expected value built in
		checkEq(4'd3, 4'd4);
		emit(hltWord);
		runProgram($sformatf("%s %s", op.name(), what), lastAddr(0), prog.size() - skipped);
	endtask

	task automatic memoryTest();
		logic [15:0] first;
		logic [15:0] second;
		first  = randWord();
		second = randWord();
		newProgram();
		loadConst(4'd1, 16'h0080);                           // Base pointer
		loadConst(4'd2, first);
		loadConst(4'd3, second);
		emit(regOp(opSw, 4'd2, 4'd1, 4'h3));                 // base + 6
		emit(regOp(opSw, 4'd3, 4'd1, 4'he));                 // base - 4
		emit(regOp(opLw, 4'd4, 4'd1, 4'h3));
		emit(regOp(opLw, 4'd6, 4'd1, 4'he));
		emit(regOp(opXor, 4'd7, 4'd2, 4'd2));
		emit(regOp(opLw, 4'd8, 4'd1, 4'h3));                 // Nonzero address, Z must survive
		branchOrFail(condEq);
		loadConst(4'd9, first);
		checkEq(4'd4, 4'd9);
		loadConst(4'd9, second);
		checkEq(4'd6, 4'd9);
		emit(hltWord);
		runProgram("LW and SW", lastAddr(0), prog.size() - skipped);
	endtask

	task automatic conditionTest(condT c, int scenario);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		opcodeT      op;
		int          s;
		logic        z;
		logic        v;
		logic        n;
		logic        taken;
		a  = randWord();
		b  = randWord();
		op = opSub;
		case (scenario)
			1: b = a;                                        // Equal, Z set
			2:
			begin
				a  = randWithTop(4'h3);                      // Positive sum, no overflow
				b  = randWithTop(4'h2);
				op = opAdd;
			end
			3:
			begin
				a  = randWithTop(4'h8);                      // Negative overflow
				b  = randWithTop(4'hb);
				op = opAdd;
			end
			default: a = randWord();
		endcase
		r = modelResult(op, a, b);
		s = trueSum(a, b, op == opSub);
		v = (s > 32767) || (s < -32768);
		n = r[15];
		z = (r == 16'h0000) || (scenario == 3);              // XOR below zeroes and sets Z only
		taken = condHolds(c, z, v, n);
		newProgram();
		loadConst(4'd1, a);
		loadConst(4'd2, b);
		emit(regOp(op, 4'd3, 4'd1, 4'd2));
		if (scenario == 3)
			emit(regOp(opXor, 4'd5, 4'd1, 4'd1));
		emit(branchOp(c, 9'd1));
		emit(hltWord);                                       // Not taken
		emit(hltWord);                                       // Taken
		runProgram($sformatf("B %s scenario %0d", c.name(), scenario),
			taken ? lastAddr(0) : lastAddr(1), prog.size() - 1);
	endtask

	task automatic subroutineTest();
		logic [15:0] retAddr;
		newProgram();
		loadConst(4'd6, 16'd16);                             // Subroutine entry, word 8
		loadConst(4'd8, 16'd4);
		retAddr = lastAddr(-1) + 16'd2 + 16'd4;              // PCS address plus 2, past BR and HLT
		emit(regOp(opPcs, 4'd5, 4'd0, 4'd0));
		emit(jumpReg(condUncond, 4'd6));
		emit(hltWord);
		emit(hltWord);                                       // Return lands here
		emit(regOp(opAdd, 4'd7, 4'd5, 4'd8));
		emit(jumpReg(condUncond, 4'd7));
		emit(hltWord);
		runProgram("PCS and BR", retAddr, 9);                // Loads, PCS, BR, ADD, BR, HLT
	endtask

	initial
	begin
		newProgram();
		emit(hltWord);
		runProgram("reset and halt", 16'h0000, 1);
		for (int i = 0; i < 3; i++)
		begin
			computeTest(opAdd, randWord(), randWord(), "random");
			computeTest(opSub, randWord(), randWord(), "random");
			computeTest(opPaddsb, randWord(), randWord(), "random");
			computeTest(opXor, randWord(), randWord(), "random");
			computeTest(opSll, randWord(), randWord(), "random");
			computeTest(opSra, randWord(), randWord(), "random");
			computeTest(opRor, randWord(), randWord(), "random");
			computeTest(opRed, randWord(), randWord(), "random");
		end
		computeTest(opAdd, randWithTop(4'h7), randWithTop(4'h4), "positive overflow");
		computeTest(opAdd, randWithTop(4'h8), randWithTop(4'hb), "negative overflow");
		computeTest(opSub, randWithTop(4'h7), randWithTop(4'h9), "positive overflow");
		computeTest(opSub, randWithTop(4'h8), randWithTop(4'h7), "negative overflow");
		memoryTest();
		for (int k = 0; k < 8; k++)
		begin
			for (int sc = 0; sc < 4; sc++)
				conditionTest(condT'(k), sc);
		end
		subroutineTest();
		finishRun();
	end

endmodule

/* bench/cpu_assert.sv */
module cpuAssert
(
	input logic                         clk,
	input logic                         arstN,
	input logic                         running,
	input logic                         hlt,
	input logic [wiscPkg::wordBits-1:0] pc,
	input logic                         dataWr,
	input logic                         regWrite
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned failCount = 0;                              // Summed by the testbench

	// Fetch stays word aligned
	pcEven: assert property (@(posedge clk) disable iff (!arstN) pc[0] == 1'b0)
	else
	begin
		$error("pc is odd: %h", pc);
		failCount++;
	end

	pcHold: assert property (@(posedge clk) disable iff (!arstN) hlt |=> $stable(pc))
	else
	begin
		$error("pc moved while halted");
		failCount++;
	end

	// First edge after reset retires nothing
	idleWrites: assert property (@(posedge clk) disable iff (!arstN)
		!running |-> pc == '0 && !dataWr && !regWrite)
	else
	begin
		$error("pc moved or write issued while core not running");
		failCount++;
	end

endmodule

bind cpuCore cpuAssert props (.clk, .arstN, .running, .hlt, .pc, .dataWr,
	.regWrite(regs.regWrite));

/* hw/wiscSystem.sv */
module wiscSystem
(
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            loadEn,
	input  logic [wiscPkg::memAddrBits-1:0] loadAddr,
	input  logic [wiscPkg::wordBits-1:0]    loadData,
	output logic [wiscPkg::wordBits-1:0]    pc,
	output logic                            hlt
);

	import wiscPkg::*;

	logic [wordBits-1:0] instr;
	logic [wordBits-1:0] dataAddr;
	logic [wordBits-1:0] dataWrData;
	logic [wordBits-1:0] dataRdData;
	logic                dataWr;

	//////////////////////////////////////////////////////////////
	// Core and memories
	//////////////////////////////////////////////////////////////

	cpuCore core (.clk, .arstN, .instr, .dataRdData, .pc, .hlt, .dataAddr, .dataWrData,
		.dataWr);

	// Loaded from outside, fetched by the core
	wordMemory instrMem (.clk, .wrEn(loadEn), .wrAddr(loadAddr), .wrData(loadData),
		.rdAddr(pc[memAddrBits:1]), .rdData(instr));

	// Byte address to word address
	wordMemory dataMem (.clk, .wrEn(dataWr), .wrAddr(dataAddr[memAddrBits:1]),
		.wrData(dataWrData), .rdAddr(dataAddr[memAddrBits:1]), .rdData(dataRdData));

endmodule

/* hw/cpuCore.sv */
module cpuCore
(
	input  logic                         clk,
	input  logic                         arstN,
	input  logic [wiscPkg::wordBits-1:0] instr,
	input  logic [wiscPkg::wordBits-1:0] dataRdData,
	output logic [wiscPkg::wordBits-1:0] pc,
	output logic                         hlt,
	output logic [wiscPkg::wordBits-1:0] dataAddr,
	output logic [wiscPkg::wordBits-1:0] dataWrData,
	output logic                         dataWr
);

	import wiscPkg::*;

	opcodeT              opcode;
	opcodeT              aluOp;
	condT                cond;
	wbSelT               wbSel;
	logic [3:0]          srcReg1;
	logic [3:0]          srcReg2;
	logic [3:0]          dstReg;
	logic                regWrite;
	logic                aluUseImm;
	logic                memWrite;
	logic                flagWrite;
	logic                branchImm;
	logic                branchReg;
	logic                halt;
	logic                running;                 // Low through reset and one edge after
	logic [wordBits-1:0] srcData1;
	logic [wordBits-1:0] srcData2;
	logic [wordBits-1:0] dstData;
	logic [wordBits-1:0] pcPlus2;
	logic [wordBits-1:0] branchTarget;
	logic [wordBits-1:0] nextPc;
	logic [wordBits-1:0] memOffset;
	logic [wordBits-1:0] immValue;
	logic [wordBits-1:0] aluIn2;
	logic [wordBits-1:0] aluResult;
	logic [wordBits-1:0] byteData;
	logic                zero;
	logic                ovfl;
	logic                neg;
	logic                flagWrZ;
	logic                flagWrVN;
	logic                taken;

	//////////////////////////////////////////////////////////////
	// Units
	//////////////////////////////////////////////////////////////

	instrDecode decode (.instr, .srcReg1, .srcReg2, .dstReg, .regWrite, .wbSel, .aluUseImm,
		.memWrite, .flagWrite, .branchImm, .branchReg, .halt, .cond);

	regFile regs (.clk, .arstN, .srcReg1, .srcReg2, .dstReg, .regWrite(regWrite && running),
		.dstData, .srcData1, .srcData2);

	alu alu (.op(aluOp), .in1(srcData1), .in2(aluIn2), .result(aluResult), .zero, .ovfl,
		.neg, .flagWrZ, .flagWrVN);

	branchUnit branch (.clk, .arstN, .flagWrite(flagWrite && running), .flagWrZ, .flagWrVN,
		.zero, .ovfl, .neg, .cond, .taken);

	//////////////////////////////////////////////////////////////
	// Operand and write-back select
	//////////////////////////////////////////////////////////////

	assign opcode    = opcodeT'(instr[15:12]);
	assign aluOp     = (opcode inside {opLw, opSw}) ? opAdd : opcode;   // Address add
	assign memOffset = {{(wordBits-5){instr[3]}}, instr[3:0], 1'b0};    // Word offset in bytes
	assign immValue  = (opcode inside {opLw, opSw}) ? memOffset : {12'b0, instr[3:0]};
	assign aluIn2    = aluUseImm ? immValue : srcData2;

	assign byteData = (opcode == opLhb) ? {instr[7:0], srcData2[7:0]}
		: {srcData2[15:8], instr[7:0]};

	always_comb
	begin
		case (wbSel)
			wbAlu:   dstData = aluResult;
			wbMem:   dstData = dataRdData;
			wbByte:  dstData = byteData;
			default: dstData = pcPlus2;                    // PCS
		endcase
	end

	// Data memory side
	assign dataAddr   = aluResult;
	assign dataWrData = srcData2;
	assign dataWr     = memWrite && running;

	//////////////////////////////////////////////////////////////
	// PC and run state
	//////////////////////////////////////////////////////////////

	assign pcPlus2      = pc + 16'd2;
	assign branchTarget = pcPlus2 + {{(wordBits-10){instr[8]}}, instr[8:0], 1'b0};

	always_comb
	begin
		if (halt)
			nextPc = pc;                                   // Hold on HLT
		else if (branchImm && taken)
			nextPc = branchTarget;
		else if (branchReg && taken)
			nextPc = srcData1;
		else
			nextPc = pcPlus2;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			running <= 1'b0;
			pc      <= '0;
		end
		else
		begin
			running <= 1'b1;
			if (running)
				pc <= nextPc;                              // One instruction per edge
		end
	end

	assign hlt = halt && running;

endmodule

/* hw/instrDecode.sv */
module instrDecode
(
	input  logic [wiscPkg::wordBits-1:0] instr,
	output logic [3:0]                   srcReg1,
	output logic [3:0]                   srcReg2,
	output logic [3:0]                   dstReg,
	output logic                         regWrite,
	output wiscPkg::wbSelT               wbSel,
	output logic                         aluUseImm,
	output logic                         memWrite,
	output logic                         flagWrite,
	output logic                         branchImm,
	output logic                         branchReg,
	output logic                         halt,
	output wiscPkg::condT                cond
);

	import wiscPkg::*;

	opcodeT opcode;

	assign opcode = opcodeT'(instr[15:12]);
	assign cond   = condT'(instr[11:9]);     // Straight to branchUnit

	always_comb
	begin
		// Quiet defaults, nothing written
		srcReg1   = '0;
		srcReg2   = '0;
		dstReg    = '0;
		regWrite  = 1'b0;
		wbSel     = wbAlu;
		aluUseImm = 1'b0;
		memWrite  = 1'b0;
		flagWrite = 1'b0;
		branchImm = 1'b0;
		branchReg = 1'b0;
		halt      = 1'b0;
		case (opcode)
			opAdd, opSub, opXor, opRed, opPaddsb:
			begin
				dstReg    = instr[11:8];
				srcReg1   = instr[7:4];
				srcReg2   = instr[3:0];
				regWrite  = 1'b1;
				flagWrite = opcode inside {opAdd, opSub, opXor};   // RED, PADDSB keep flags
			end
			opSll, opSra, opRor:
			begin
				dstReg    = instr[11:8];
				srcReg1   = instr[7:4];
				aluUseImm = 1'b1;                               // Shift amount in [3:0]
				regWrite  = 1'b1;
				flagWrite = 1'b1;
			end
			opLw:
			begin
				dstReg    = instr[11:8];
				srcReg1   = instr[7:4];                         // Base
				aluUseImm = 1'b1;
				regWrite  = 1'b1;
				wbSel     = wbMem;
			end
			opSw:
			begin
				srcReg1   = instr[7:4];
				srcReg2   = instr[11:8];                        // Store data from rt
				aluUseImm = 1'b1;
				memWrite  = 1'b1;
			end
			opLlb, opLhb:
			begin
				dstReg   = instr[11:8];
				srcReg2  = instr[11:8];                         // Keep the other byte
				regWrite = 1'b1;
				wbSel    = wbByte;
			end
			opB:   branchImm = 1'b1;
			opBr:
			begin
				srcReg1   = instr[7:4];                         // Target register
				branchReg = 1'b1;
			end
			opPcs:
			begin
				dstReg   = instr[11:8];
				regWrite = 1'b1;
				wbSel    = wbPcPlus2;
			end
			default: halt = 1'b1;                               // HLT
		endcase
	end

endmodule

/* hw/wordMemory.sv */
module wordMemory
(
	input  logic                            clk,
	input  logic                            wrEn,
	input  logic [wiscPkg::memAddrBits-1:0] wrAddr,
	input  logic [wiscPkg::wordBits-1:0]    wrData,
	input  logic [wiscPkg::memAddrBits-1:0] rdAddr,
	output logic [wiscPkg::wordBits-1:0]    rdData
);

	import wiscPkg::*;

	//////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////

	logic [wordBits-1:0] mem [2**memAddrBits];   // Contents undefined until written

	// Synchronous write
	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// Asynchronous read, same-cycle data
	assign rdData = mem[rdAddr];

endmodule

/* hw/branchUnit.sv */
module branchUnit
(
	input  logic          clk,
	input  logic          arstN,
	input  logic          flagWrite,
	input  logic          flagWrZ,
	input  logic          flagWrVN,
	input  logic          zero,
	input  logic          ovfl,
	input  logic          neg,
	input  wiscPkg::condT cond,
	output logic          taken
);

	import wiscPkg::*;

	logic zFlag;
	logic vFlag;
	logic nFlag;

	// Flag register, each group under its own enable
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			zFlag <= 1'b0;
			vFlag <= 1'b0;
			nFlag <= 1'b0;
		end
		else if (flagWrite)
		begin
			if (flagWrZ)
				zFlag <= zero;
			if (flagWrVN)
			begin
				vFlag <= ovfl;
				nFlag <= neg;
			end
		end
	end

	// Condition table against stored flags
	always_comb
	begin
		case (cond)
			condNe:  taken = !zFlag;
			condEq:  taken = zFlag;
			condGt:  taken = !zFlag && !nFlag;
			condLt:  taken = nFlag;
			condGe:  taken = zFlag || (!zFlag && !nFlag);
			condLe:  taken = nFlag || zFlag;
			condOv:  taken = vFlag;
			default: taken = 1'b1;                          // Unconditional
		endcase
	end

endmodule

/* hw/alu.sv */
module alu
(
	input  wiscPkg::opcodeT              op,
	input  logic [wiscPkg::wordBits-1:0] in1,
	input  logic [wiscPkg::wordBits-1:0] in2,
	output logic [wiscPkg::wordBits-1:0] result,
	output logic                         zero,
	output logic                         ovfl,
	output logic                         neg,
	output logic                         flagWrZ,
	output logic                         flagWrVN
);

	import wiscPkg::*;

	logic [wordBits-1:0]   addRaw;
	logic [wordBits-1:0]   subRaw;
	logic                  addOv;
	logic                  subOv;
	logic [9:0]            redSum;     // Four signed bytes fit in 10 bits
	logic [3:0]            shAmt;
	logic [2*wordBits-1:0] rotWide;
	logic [wordBits-1:0]   paddsb;

	assign shAmt  = in2[3:0];          // Shift count from immediate
	assign addRaw = in1 + in2;
	assign subRaw = in1 - in2;

	// Signed overflow from operand and result signs
	assign addOv = (in1[wordBits-1] == in2[wordBits-1])
		&& (addRaw[wordBits-1] != in1[wordBits-1]);
	assign subOv = (in1[wordBits-1] != in2[wordBits-1])
		&& (subRaw[wordBits-1] != in1[wordBits-1]);

	// Byte reduction, each byte sign extended
	assign redSum = {{2{in1[15]}}, in1[15:8]} + {{2{in1[7]}}, in1[7:0]}
		+ {{2{in2[15]}}, in2[15:8]} + {{2{in2[7]}}, in2[7:0]};

	assign rotWide = {in1, in1} >> shAmt;   // Low half is the rotation

	//////////////////////////////////////////////////////////////
	// Nibble-wise saturating add
	//////////////////////////////////////////////////////////////

	always_comb
	begin : nibbleAdd
		logic [3:0] a;
		logic [3:0] b;
		logic [3:0] s;
		paddsb = '0;
		for (int i = 0; i < 4; i++)
		begin
			a = in1[4*i +: 4];
			b = in2[4*i +: 4];
			s = a + b;
			if (a[3] == b[3] && s[3] != a[3])
				paddsb[4*i +: 4] = a[3] ? 4'h8 : 4'h7;   // Clamp to signed nibble
			else
				paddsb[4*i +: 4] = s;
		end
	end

	//////////////////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		ovfl = 1'b0;
		case (op)
			opAdd:
			begin
				result = addOv ? (in1[wordBits-1] ? wordMin : wordMax) : addRaw;
				ovfl   = addOv;
			end
			opSub:
			begin
				result = subOv ? (in1[wordBits-1] ? wordMin : wordMax) : subRaw;
				ovfl   = subOv;
			end
			opXor:    result = in1 ^ in2;
			opRed:    result = {{(wordBits-10){redSum[9]}}, redSum};
			opSll:    result = in1 << shAmt;
			opSra:    result = $signed(in1) >>> shAmt;     // Sign fills from the top
			opRor:    result = rotWide[wordBits-1:0];
			opPaddsb: result = paddsb;
			default:  result = '0;                          // Not a compute opcode
		endcase
	end

	assign zero = (result == '0);
	assign neg  = result[wordBits-1];

	// Which flags this opcode may touch
	assign flagWrZ  = op inside {opAdd, opSub, opXor, opSll, opSra, opRor};
	assign flagWrVN = op inside {opAdd, opSub};

endmodule

/* hw/regFile.sv */
module regFile
(
	input  logic                         clk,
	input  logic                         arstN,
	input  logic [3:0]                   srcReg1,
	input  logic [3:0]                   srcReg2,
	input  logic [3:0]                   dstReg,
	input  logic                         regWrite,
	input  logic [wiscPkg::wordBits-1:0] dstData,
	output logic [wiscPkg::wordBits-1:0] srcData1,
	output logic [wiscPkg::wordBits-1:0] srcData2
);

	import wiscPkg::*;

	logic [wordBits-1:0] regs [16];   // R0 slot never written

	//////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;                    // All registers cleared
		end
		else if (regWrite && dstReg != 4'd0)
		begin
			regs[dstReg] <= dstData;
		end
	end

	//////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////

	// No bypass, a same-cycle write shows up after the edge
	assign srcData1 = (srcReg1 == 4'd0) ? '0 : regs[srcReg1];
	assign srcData2 = (srcReg2 == 4'd0) ? '0 : regs[srcReg2];   // R0 reads zero

endmodule

/* hw/wiscPkg.sv */
package wiscPkg;

	//////////////////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////////////////

	localparam int wordBits    = 16;          // Data and byte-address width
	localparam int memAddrBits = 8;           // 256 words per memory

	localparam logic [wordBits-1:0] wordMax = 16'h7fff;   // Signed saturation ceiling
	localparam logic [wordBits-1:0] wordMin = 16'h8000;   // Signed saturation floor

	//////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////

	// Opcode sits in instr[15:12]
	typedef enum logic [3:0]
	{
		opAdd    = 4'd0,
		opSub    = 4'd1,
		opXor    = 4'd2,
		opRed    = 4'd3,
		opSll    = 4'd4,
		opSra    = 4'd5,
		opRor    = 4'd6,
		opPaddsb = 4'd7,
		opLw     = 4'd8,
		opSw     = 4'd9,
		opLlb    = 4'd10,
		opLhb    = 4'd11,
		opB      = 4'd12,
		opBr     = 4'd13,
		opPcs    = 4'd14,
		opHlt    = 4'd15
	} opcodeT;

	// Branch condition in instr[11:9]
	typedef enum logic [2:0]
	{
		condNe, condEq, condGt, condLt, condGe, condLe, condOv, condUncond
	} condT;

	// Register write-back source
	typedef enum logic [1:0]
	{
		wbAlu, wbMem, wbByte, wbPcPlus2
	} wbSelT;

endpackage
